/* Makefile */
sim:
	verilator --binary -Wno-fatal --timescale 1ns/100ps --top-module fp_adder_tb -f src.f
	./obj_dir/Vfp_adder_tb | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* src.f */
verilog/fp_format_pkg.sv
verilog/fp_adder_pkg.sv
verilog/b_right_shifter.sv
verilog/fp_align.sv
verilog/fp_add_stage.sv
verilog/fp_normalize_round.sv
verilog/fp_adder_top.sv
verif/tb_clock_gen.sv
verif/fp_adder_tb.sv

/* verif/fp_add_patterns.txt */
// op_a op_b sub expected_result flags
// flags: bit 1 overflow, bit 0 zero
3F800000 3F800000 0 40000000 0
3FC00000 3FC00000 0 40400000 0
3F800000 3F000000 0 3FC00000 0
40400000 3F800000 0 40800000 0
3F800000 34000000 0 3F800001 0
3F800000 33800000 0 3F800000 0
3F800000 21800000 0 3F800000 0
3F800000 3FFFFFFF 0 403FFFFF 0
BF800000 BFC00000 0 C0200000 0
7E800000 7E800000 0 7F000000 0
40400000 3F800000 1 40000000 0
3F800000 40400000 1 C0000000 0
3F800001 3F800000 1 34000000 0
40000000 3FFFFFFF 1 34000000 0
40A00000 BFC00000 0 40600000 0
BF800000 C0400000 1 40000000 0
3F800000 33800000 1 3F7FFFFF 0
3FC00000 3FC00000 1 00000000 1
C0000000 40000000 0 00000000 1
00000000 40400000 0 40400000 0
40400000 00000000 1 40400000 0
00000000 40400000 1 C0400000 0
00000001 40200000 0 40200000 0
80000000 80000000 0 00000000 1
7F7FFFFF 7F7FFFFF 0 7F7FFFFF 2
FF7FFFFF FF000000 0 FF7FFFFF 2
00800001 00800000 1 00000000 1
00C00000 00800000 1 00000000 1
01000000 00800000 1 00800000 0

/* verif/fp_adder_tb.sv */
`timescale 1ns/100ps

module fp_adder_tb;

	localparam int NUM_PATTERNS = 29;
	localparam int FIELDS       = 5;
	localparam int LATENCY      = 3;
	localparam int BURST_LEN    = 6;  // last patterns go back to back
	localparam int IDLE_START   = 5;
	localparam int MAX_CYCLES   = NUM_PATTERNS * 3 + 3 + 20;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic        sub;
	logic        out_valid;
	logic [31:0] result;
	logic        overflow;
	logic        zero;

	logic [31:0] patterns [NUM_PATTERNS*FIELDS];
	int          pending_idx[$];
	int          pending_cycle[$];  // cycle the operation is driven in
	int          cycle_count = 0;
	int          error_count = 0;
	int          checked_count = 0;
	integer      seed;

	tb_clock_gen tb_clock_gen_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	fp_adder_top fp_adder_top_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.op_a      (op_a),
		.op_b      (op_b),
		.sub       (sub),
		.out_valid (out_valid),
		.result    (result),
		.overflow  (overflow),
		.zero      (zero)
	);

	task automatic finish_run();
		$display("checked %0d of %0d operations, %0d errors", checked_count, NUM_PATTERNS,
			error_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	endtask

	task automatic issue_op(input int idx);
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		op_a     = patterns[idx*FIELDS];
		op_b     = patterns[idx*FIELDS+1];
		sub      = patterns[idx*FIELDS+2][0];
		pending_idx.push_back(idx);
		pending_cycle.push_back(cycle_count);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
			in_valid = 1'b0;
		end
	endtask

	task automatic check_output();
		int          idx;
		int          stamp;
		logic [31:0] exp_result;
		logic [31:0] exp_flags;
		if (pending_idx.size() == 0)
		begin
			$display("out_valid high at cycle %0d with no operation in flight", cycle_count);
			error_count++;
		end
		else
		begin
			idx        = pending_idx.pop_front();
			stamp      = pending_cycle.pop_front();
			exp_result = patterns[idx*FIELDS+3];
			exp_flags  = patterns[idx*FIELDS+4];  // {overflow, zero}
			checked_count++;
			if (cycle_count - stamp != LATENCY)
			begin
				$display("pattern %0d came out after %0d cycles instead of %0d", idx,
					cycle_count - stamp, LATENCY);
				error_count++;
			end
			if (result !== exp_result)
			begin
				$display("[FAIL] result: expected %08h, got %08h (pattern %0d)", exp_result,
					result, idx);
				error_count++;
			end
			if (overflow !== exp_flags[1])
			begin
				$display("[FAIL] overflow: expected %h, got %h (pattern %0d)", exp_flags[1],
					overflow, idx);
				error_count++;
			end
			if (zero !== exp_flags[0])
			begin
				$display("[FAIL] zero: expected %h, got %h (pattern %0d)", exp_flags[0],
					zero, idx);
				error_count++;
			end
		end
	endtask

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > MAX_CYCLES)
		begin
			$display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
			error_count++;
			finish_run();
		end
	end

	// outputs are settled by the falling edge
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			if (out_valid)
				check_output();
			else if (pending_idx.size() != 0 && cycle_count - pending_cycle[0] >= LATENCY)
			begin
				$display("no output for pattern %0d by cycle %0d", pending_idx[0], cycle_count);
				error_count++;
				void'(pending_idx.pop_front());
				void'(pending_cycle.pop_front());
			end
		end
	end

	initial
	begin
		int gap;
		in_valid = 1'b0;
		op_a     = '0;
		op_b     = '0;
		sub      = 1'b0;
		seed     = 32'h1026;
		$readmemh("verif/fp_add_patterns.txt", patterns);

		@(posedge rst_n);
		idle_cycles(IDLE_START);  // out_valid must stay low here

		for (int i = 0; i < NUM_PATTERNS; i++)
		begin
			if (i < NUM_PATTERNS - BURST_LEN)
				gap = $unsigned($random(seed)) % 3;
			else
				gap = 0;
			issue_op(i);
			idle_cycles(gap);
		end
		idle_cycles(1);

		while (pending_idx.size() != 0)
			@(posedge clk);
		repeat (LATENCY) @(posedge clk);  // catch stray pulses
		finish_run();
	end

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD  = 50;  // 100 ns clock
	localparam int RESET_CYCLES = 3;

	initial
	begin
		clk = 1'b0;
		forever
			#(HALF_PERIOD) clk = ~clk;
	end

	// release just after an edge, like the other inputs
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

/* verilog/b_right_shifter.sv */
`timescale 1ns/100ps

module b_right_shifter (
	input  logic [fp_adder_pkg::PATH_WIDTH-1:0]  shift_in,
	input  logic [fp_adder_pkg::SHIFT_WIDTH-1:0] shift_value,
	output logic [fp_adder_pkg::PATH_WIDTH-1:0]  shift_out
);

	import fp_adder_pkg::*;

	// log shifter, one stage per bit of the amount
	logic [PATH_WIDTH-1:0] by_1;
	logic [PATH_WIDTH-1:0] by_2;
	logic [PATH_WIDTH-1:0] by_4;
	logic [PATH_WIDTH-1:0] by_8;
	logic [PATH_WIDTH-1:0] by_16;

	assign by_1  = shift_value[0] ? (shift_in >> 1) : shift_in;
	assign by_2  = shift_value[1] ? (by_1 >> 2) : by_1;
	assign by_4  = shift_value[2] ? (by_2 >> 4) : by_2;
	assign by_8  = shift_value[3] ? (by_4 >> 8) : by_4;
	assign by_16 = shift_value[4] ? (by_8 >> 16) : by_8;

	// 48 and up clears the word
	assign shift_out = shift_value[5] ? (by_16 >> 32) : by_16;

endmodule

/* verilog/fp_add_stage.sv */
`timescale 1ns/100ps

module fp_add_stage (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 s1_valid,
	input  logic                                 s1_sign,
	input  logic [fp_format_pkg::EXP_WIDTH-1:0]  s1_exp,
	input  logic                                 s1_eff_sub,
	input  logic [fp_adder_pkg::PATH_WIDTH-1:0]  s1_mant_big,
	input  logic [fp_adder_pkg::PATH_WIDTH-1:0]  s1_mant_small,
	output logic                                 s2_valid,
	output logic                                 s2_sign,
	output logic [fp_format_pkg::EXP_WIDTH-1:0]  s2_exp,
	output logic [fp_adder_pkg::SUM_WIDTH-1:0]   s2_sum
);

	import fp_adder_pkg::*;

	logic [SUM_WIDTH-1:0] sum;

	// big >= small by construction, difference never wraps
	always_comb
	begin
		if (s1_eff_sub)
			sum = {1'b0, s1_mant_big} - {1'b0, s1_mant_small};
		else
			sum = {1'b0, s1_mant_big} + {1'b0, s1_mant_small};
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			s2_valid <= 1'b0;
		else
			s2_valid <= s1_valid;
	end

	always_ff @(posedge clk)
	begin
		if (s1_valid)
		begin
			s2_sign <= s1_sign;
			s2_exp  <= s1_exp;
			s2_sum  <= sum;
		end
	end

endmodule

/* verilog/fp_adder_pkg.sv */
package fp_adder_pkg;

	// significand including the hidden one
	localparam int MANT_WIDTH = fp_format_pkg::FRAC_WIDTH + 1;

	// operand in upper half, lower half catches bits shifted out
	localparam int PATH_WIDTH = 2 * MANT_WIDTH;

	localparam int SHIFT_WIDTH = 6;
	localparam int MAX_SHIFT   = 48;  // beyond this the small operand is gone

	localparam int SUM_WIDTH = PATH_WIDTH + 1;  // one carry bit

endpackage

/* verilog/fp_adder_top.sv */
`timescale 1ns/100ps

module fp_adder_top (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                in_valid,
	input  logic [fp_format_pkg::FP_WIDTH-1:0]  op_a,
	input  logic [fp_format_pkg::FP_WIDTH-1:0]  op_b,
	input  logic                                sub,
	output logic                                out_valid,
	output logic [fp_format_pkg::FP_WIDTH-1:0]  result,
	output logic                                overflow,
	output logic                                zero
);

	import fp_format_pkg::*;
	import fp_adder_pkg::*;

	fp_word_t op_a_w;
	fp_word_t op_b_w;
	fp_word_t result_w;

	// stage 1 to 2
	logic                  s1_valid;
	logic                  s1_sign;
	logic [EXP_WIDTH-1:0]  s1_exp;
	logic                  s1_eff_sub;
	logic [PATH_WIDTH-1:0] s1_mant_big;
	logic [PATH_WIDTH-1:0] s1_mant_small;

	// stage 2 to 3
	logic                  s2_valid;
	logic                  s2_sign;
	logic [EXP_WIDTH-1:0]  s2_exp;
	logic [SUM_WIDTH-1:0]  s2_sum;

	assign op_a_w.raw = op_a;
	assign op_b_w.raw = op_b;
	assign result     = result_w.raw;

	fp_align fp_align_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.op_a          (op_a_w),
		.op_b          (op_b_w),
		.sub           (sub),
		.s1_valid      (s1_valid),
		.s1_sign       (s1_sign),
		.s1_exp        (s1_exp),
		.s1_eff_sub    (s1_eff_sub),
		.s1_mant_big   (s1_mant_big),
		.s1_mant_small (s1_mant_small)
	);

	fp_add_stage fp_add_stage_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.s1_valid      (s1_valid),
		.s1_sign       (s1_sign),
		.s1_exp        (s1_exp),
		.s1_eff_sub    (s1_eff_sub),
		.s1_mant_big   (s1_mant_big),
		.s1_mant_small (s1_mant_small),
		.s2_valid      (s2_valid),
		.s2_sign       (s2_sign),
		.s2_exp        (s2_exp),
		.s2_sum        (s2_sum)
	);

	fp_normalize_round fp_normalize_round_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.s2_valid  (s2_valid),
		.s2_sign   (s2_sign),
		.s2_exp    (s2_exp),
		.s2_sum    (s2_sum),
		.out_valid (out_valid),
		.result    (result_w),
		.overflow  (overflow),
		.zero      (zero)
	);

endmodule

/* verilog/fp_align.sv */
`timescale 1ns/100ps

module fp_align (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 in_valid,
	input  fp_format_pkg::fp_word_t              op_a,
	input  fp_format_pkg::fp_word_t              op_b,
	input  logic                                 sub,
	output logic                                 s1_valid,
	output logic                                 s1_sign,
	output logic [fp_format_pkg::EXP_WIDTH-1:0]  s1_exp,
	output logic                                 s1_eff_sub,
	output logic [fp_adder_pkg::PATH_WIDTH-1:0]  s1_mant_big,
	output logic [fp_adder_pkg::PATH_WIDTH-1:0]  s1_mant_small
);

	import fp_format_pkg::*;
	import fp_adder_pkg::*;

	logic                   sign_a;
	logic                   sign_b;
	logic [EXP_WIDTH-1:0]   exp_a;
	logic [EXP_WIDTH-1:0]   exp_b;
	logic [MANT_WIDTH-1:0]  mant_a;
	logic [MANT_WIDTH-1:0]  mant_b;
	logic                   a_ge_b;

	logic                   sign_big;
	logic [EXP_WIDTH-1:0]   exp_big;
	logic [EXP_WIDTH-1:0]   exp_small;
	logic [MANT_WIDTH-1:0]  mant_big;
	logic [MANT_WIDTH-1:0]  mant_small;
	logic [EXP_WIDTH-1:0]   exp_diff;
	logic [SHIFT_WIDTH-1:0] shift_amt;
	logic [PATH_WIDTH-1:0]  small_aligned;

	assign sign_a = op_a.fields.sign;
	assign sign_b = op_b.fields.sign ^ sub;  // a - b is a + (-b)
	assign exp_a  = op_a.fields.exponent;
	assign exp_b  = op_b.fields.exponent;

	// exponent 0 counts as zero, subnormals flushed
	assign mant_a = (exp_a == '0) ? '0 : {1'b1, op_a.fields.fraction};
	assign mant_b = (exp_b == '0) ? '0 : {1'b1, op_b.fields.fraction};

	// magnitude compare on exponent then significand
	assign a_ge_b = {exp_a, mant_a} >= {exp_b, mant_b};

	assign sign_big   = a_ge_b ? sign_a : sign_b;
	assign exp_big    = a_ge_b ? exp_a : exp_b;
	assign exp_small  = a_ge_b ? exp_b : exp_a;
	assign mant_big   = a_ge_b ? mant_a : mant_b;
	assign mant_small = a_ge_b ? mant_b : mant_a;

	assign exp_diff  = exp_big - exp_small;
	assign shift_amt = (exp_diff > MAX_SHIFT) ? SHIFT_WIDTH'(MAX_SHIFT) : exp_diff[SHIFT_WIDTH-1:0];

	b_right_shifter b_right_shifter_i (
		.shift_in    ({mant_small, {MANT_WIDTH{1'b0}}}),
		.shift_value (shift_amt),
		.shift_out   (small_aligned)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			s1_sign       <= sign_big;
			s1_exp        <= exp_big;
			s1_eff_sub    <= sign_a ^ sign_b;  // signs differ
			s1_mant_big   <= {mant_big, {MANT_WIDTH{1'b0}}};
			s1_mant_small <= small_aligned;
		end
	end

endmodule

/* verilog/fp_format_pkg.sv */
package fp_format_pkg;

	// ieee-754 single precision layout
	localparam int FP_WIDTH   = 32;
	localparam int EXP_WIDTH  = 8;
	localparam int FRAC_WIDTH = 23;

	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX  = 254;  // 255 is inf/nan, not supported

	typedef struct packed
	{
		logic                  sign;
		logic [EXP_WIDTH-1:0]  exponent;
		logic [FRAC_WIDTH-1:0] fraction;
	} fp_fields_t;

	// same word, seen as a bus or as its fields
	typedef union packed
	{
		logic [FP_WIDTH-1:0] raw;
		fp_fields_t          fields;
	} fp_word_t;

endpackage

/* verilog/fp_normalize_round.sv */
`timescale 1ns/100ps

module fp_normalize_round (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 s2_valid,
	input  logic                                 s2_sign,
	input  logic [fp_format_pkg::EXP_WIDTH-1:0]  s2_exp,
	input  logic [fp_adder_pkg::SUM_WIDTH-1:0]   s2_sum,
	output logic                                 out_valid,
	output fp_format_pkg::fp_word_t              result,
	output logic                                 overflow,
	output logic                                 zero
);

	import fp_format_pkg::*;
	import fp_adder_pkg::*;

	logic [SHIFT_WIDTH-1:0]      lead_zeros;
	logic [PATH_WIDTH-1:0]       shifted;
	logic [MANT_WIDTH-1:0]       mant_norm;
	logic signed [EXP_WIDTH+1:0] exp_norm;  // room for carry and underflow
	logic                        zero_d;
	logic                        overflow_d;
	fp_word_t                    result_d;

	// leading zeros above the hidden-bit position, highest one wins
	always_comb
	begin
		lead_zeros = '0;
		for (int i = 0; i < PATH_WIDTH; i++)
		begin
			if (s2_sum[i])
				lead_zeros = SHIFT_WIDTH'(PATH_WIDTH - 1 - i);
		end
	end

	assign shifted = s2_sum[PATH_WIDTH-1:0] << lead_zeros;

	always_comb
	begin
		if (s2_sum[SUM_WIDTH-1])
		begin
			// carry out, drop one bit and bump exponent
			mant_norm = s2_sum[SUM_WIDTH-1 -: MANT_WIDTH];
			exp_norm  = $signed({2'b00, s2_exp}) + 1;
		end
		else
		begin
			mant_norm = shifted[PATH_WIDTH-1 -: MANT_WIDTH];  // truncate
			exp_norm  = $signed({2'b00, s2_exp}) - $signed({4'b0000, lead_zeros});
		end
	end

	assign zero_d     = (s2_sum == '0) || (exp_norm < 1);
	assign overflow_d = !zero_d && (exp_norm > EXP_MAX);

	always_comb
	begin
		if (zero_d)
		begin
			result_d.raw = '0;  // always +0
		end
		else if (overflow_d)
		begin
			// saturate to largest finite
			result_d.fields.sign     = s2_sign;
			result_d.fields.exponent = EXP_WIDTH'(EXP_MAX);
			result_d.fields.fraction = '1;
		end
		else
		begin
			result_d.fields.sign     = s2_sign;
			result_d.fields.exponent = exp_norm[EXP_WIDTH-1:0];
			result_d.fields.fraction = mant_norm[FRAC_WIDTH-1:0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= s2_valid;
	end

	always_ff @(posedge clk)
	begin
		if (s2_valid)
		begin
			result   <= result_d;
			overflow <= overflow_d;
			zero     <= zero_d;
		end
	end

endmodule
